//--- verilog/cam_disp_pkg.sv
`default_nettype none

package cam_disp_pkg;

    // one camera pixel as the sensor sends it, red in the top bits
    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } rgb565_t;

    // memory word, raw for the array and split into fields for display
    typedef union packed {
        logic [15:0] raw;
        rgb565_t     rgb;
    } pixel_word_u;

    // capture to store, 18 bits
    typedef struct packed {
        logic        valid;   // one-cycle strobe per pixel
        logic        sof;     // first pixel after vsync fall
        pixel_word_u pix;
    } cap_pixel_t;

    // raster control, all active high
    typedef struct packed {
        logic hs;
        logic vs;
        logic de;
    } video_ctl_t;

    // active display position being fetched
    typedef struct packed {
        logic [11:0] x;
        logic [11:0] y;
    } raster_pos_t;

    // widened colour toward the hdmi encoder
    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb888_t;

endpackage

`default_nettype wire

//--- verilog/dvp_capture.sv
`timescale 1ns/1ps
`default_nettype none

module dvp_capture #(
    parameter int IMAGE_WIDTH  = 1280,
    parameter int IMAGE_HEIGHT = 720
) (
    input  wire logic                pclk,
    input  wire logic                rst,
    input  wire logic                camera_vsync,
    input  wire logic                camera_href,
    input  wire logic [7:0]          camera_data,
    output cam_disp_pkg::cap_pixel_t cap
);
    import cam_disp_pkg::*;

    localparam int FRAME_PIXELS = IMAGE_WIDTH * IMAGE_HEIGHT;
    localparam int CNT_W        = $clog2(FRAME_PIXELS + 1);

    logic             vsync_d;       // last vsync for the falling edge
    logic             second_byte;   // next byte closes a pixel
    logic             sof_armed;     // set by vsync fall and cleared by first pixel
    logic [CNT_W-1:0] pix_cnt;       // pixels taken since vsync fell
    logic [7:0]       first_byte;    // red and green 5:3
    logic             pix_valid;
    logic             pix_sof;
    pixel_word_u      pix_word;

    logic vsync_fall;
    logic frame_full;
    logic take_byte;
    logic pair_done;
    logic pix_accept;

    assign vsync_fall = vsync_d & ~camera_vsync;
    assign take_byte  = camera_href & ~camera_vsync;   // bytes during vsync dropped
    assign pair_done  = take_byte & second_byte;
    // extra pixels past one frame would wrap onto the top lines
    assign frame_full = (pix_cnt == CNT_W'(FRAME_PIXELS));
    assign pix_accept = pair_done & ~frame_full;

    always_ff @(posedge pclk) begin
        if (rst) begin
            vsync_d     <= 1'b0;
            second_byte <= 1'b0;
            sof_armed   <= 1'b0;
            pix_cnt     <= '0;
            pix_valid   <= 1'b0;
            pix_sof     <= 1'b0;
        end else begin
            vsync_d   <= camera_vsync;
            pix_valid <= pix_accept;               // one clock after 2nd byte
            pix_sof   <= pix_accept & sof_armed;

            // phase held clear while href is low so each href run starts on a first byte
            if (!take_byte)
                second_byte <= 1'b0;
            else
                second_byte <= ~second_byte;

            if (vsync_fall)
                sof_armed <= 1'b1;
            else if (pix_accept)
                sof_armed <= 1'b0;

            if (vsync_fall)
                pix_cnt <= '0;
            else if (pix_accept)
                pix_cnt <= pix_cnt + 1'b1;
        end
    end

    // byte payload
    always_ff @(posedge pclk) begin
        if (take_byte && !pair_done)
            first_byte <= camera_data;
        if (pair_done)
            pix_word.raw <= {first_byte, camera_data};   // green 2:0 and blue in low byte
    end

    assign cap = {pix_valid, pix_sof, pix_word};

endmodule

`default_nettype wire

//--- verilog/frame_store.sv
`timescale 1ns/1ps
`default_nettype none

module frame_store #(
    parameter int IMAGE_WIDTH  = 1280,
    parameter int IMAGE_HEIGHT = 720
) (
    input  wire logic                      pclk,
    input  wire logic                      rst,
    input  wire cam_disp_pkg::cap_pixel_t  cap,
    input  wire cam_disp_pkg::raster_pos_t pos,
    input  wire cam_disp_pkg::video_ctl_t  ctl_in,
    output cam_disp_pkg::pixel_word_u      rd_pix,
    output cam_disp_pkg::video_ctl_t       ctl_out
);

    localparam int DEPTH  = IMAGE_WIDTH * IMAGE_HEIGHT;
    localparam int ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [15:0]       mem [0:DEPTH-1];   // one frame, raster order
    logic [ADDR_W-1:0] wr_addr;           // where the next non-sof pixel lands
    logic [ADDR_W-1:0] wr_sel;
    logic [ADDR_W-1:0] wr_next;
    logic [ADDR_W-1:0] rd_addr;

    // sof pixel always goes to the top left
    assign wr_sel = cap.sof ? '0 : wr_addr;

    always_comb begin
        if (wr_sel == ADDR_W'(DEPTH - 1))
            wr_next = '0;                   // wrap at frame size
        else
            wr_next = wr_sel + 1'b1;
    end

    // y * width + x, pos is already limited to the active area
    assign rd_addr = ADDR_W'(pos.y * IMAGE_WIDTH + pos.x);

    always_ff @(posedge pclk) begin
        if (rst) begin
            wr_addr <= '0;
        end else if (cap.valid) begin
            wr_addr <= wr_next;
        end
    end

    always_ff @(posedge pclk) begin
        if (cap.valid)
            mem[wr_sel] <= cap.pix.raw;
        rd_pix.raw <= mem[rd_addr];          // registered read, one cycle
    end

    // control follows the read data by the same cycle
    always_ff @(posedge pclk) begin
        if (rst) begin
            ctl_out <= '0;
        end else begin
            ctl_out <= ctl_in;
        end
    end

endmodule

`default_nettype wire

//--- verilog/video_timing.sv
`timescale 1ns/1ps
`default_nettype none

module video_timing #(
    parameter int IMAGE_WIDTH  = 1280,
    parameter int IMAGE_HEIGHT = 720,
    parameter int H_FRONT      = 110,
    parameter int H_SYNC       = 40,
    parameter int H_BACK       = 220,
    parameter int V_FRONT      = 5,
    parameter int V_SYNC       = 5,
    parameter int V_BACK       = 20
) (
    input  wire logic                pclk,
    input  wire logic                rst,
    output cam_disp_pkg::raster_pos_t pos,
    output cam_disp_pkg::video_ctl_t  ctl
);

    // horizontal line: active, front porch, sync, back porch
    localparam logic [11:0] H_ACTIVE     = 12'(IMAGE_WIDTH);
    localparam logic [11:0] H_SYNC_START = 12'(IMAGE_WIDTH + H_FRONT);
    localparam logic [11:0] H_SYNC_END   = 12'(IMAGE_WIDTH + H_FRONT + H_SYNC);
    localparam logic [11:0] H_LAST       = 12'(IMAGE_WIDTH + H_FRONT + H_SYNC + H_BACK - 1);

    // vertical, counted in lines
    localparam logic [11:0] V_ACTIVE     = 12'(IMAGE_HEIGHT);
    localparam logic [11:0] V_SYNC_START = 12'(IMAGE_HEIGHT + V_FRONT);
    localparam logic [11:0] V_SYNC_END   = 12'(IMAGE_HEIGHT + V_FRONT + V_SYNC);
    localparam logic [11:0] V_LAST       = 12'(IMAGE_HEIGHT + V_FRONT + V_SYNC + V_BACK - 1);

    logic [11:0] h_cnt;
    logic [11:0] v_cnt;
    logic        h_active;
    logic        v_active;
    logic        line_end;

    assign line_end = (h_cnt == H_LAST);

    always_ff @(posedge pclk) begin
        if (rst) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else begin
            if (line_end) begin
                h_cnt <= '0;
                // vertical steps once per line
                if (v_cnt == V_LAST)
                    v_cnt <= '0;
                else
                    v_cnt <= v_cnt + 1'b1;
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
        end
    end

    assign h_active = (h_cnt < H_ACTIVE);
    assign v_active = (v_cnt < V_ACTIVE);

    // raw raster control, still 2 cycles ahead of the pins
    assign ctl.hs = (h_cnt >= H_SYNC_START) && (h_cnt < H_SYNC_END);
    assign ctl.vs = (v_cnt >= V_SYNC_START) && (v_cnt < V_SYNC_END);
    assign ctl.de = h_active & v_active;

    // held at 0 in blanking so the memory read stays in range
    assign pos.x = h_active ? h_cnt : '0;
    assign pos.y = v_active ? v_cnt : '0;

endmodule

`default_nettype wire

//--- verilog/pixel_expand.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_expand (
    input  wire logic                      pclk,
    input  wire logic                      rst,
    input  wire cam_disp_pkg::pixel_word_u rd_pix,
    input  wire cam_disp_pkg::video_ctl_t  ctl_in,
    output cam_disp_pkg::video_ctl_t       ctl,
    output cam_disp_pkg::rgb888_t          rgb
);
    import cam_disp_pkg::*;

    rgb888_t rgb_next;

    // zero low bits appended, black outside de
    always_comb begin
        rgb_next = '0;
        if (ctl_in.de) begin
            rgb_next.red   = {rd_pix.rgb.red, 3'b000};
            rgb_next.green = {rd_pix.rgb.green, 2'b00};
            rgb_next.blue  = {rd_pix.rgb.blue, 3'b000};
        end
    end

    // output register, second of the two display cycles
    always_ff @(posedge pclk) begin
        if (rst) begin
            ctl <= '0;
            rgb <= '0;
        end else begin
            ctl <= ctl_in;
            rgb <= rgb_next;
        end
    end

endmodule

`default_nettype wire

//--- verilog/cam_disp_top.sv
`timescale 1ns/1ps
`default_nettype none

module cam_disp_top #(
    parameter int IMAGE_WIDTH  = 1280,
    parameter int IMAGE_HEIGHT = 720,
    parameter int H_FRONT      = 110,   // 720p60 blanking
    parameter int H_SYNC       = 40,
    parameter int H_BACK       = 220,
    parameter int V_FRONT      = 5,
    parameter int V_SYNC       = 5,
    parameter int V_BACK       = 20
) (
    input  wire logic       pclk,          // shared camera and display clock
    input  wire logic       rst,
    input  wire logic       camera_vsync,
    input  wire logic       camera_href,
    input  wire logic [7:0] camera_data,
    output logic            video_hs,
    output logic            video_vs,
    output logic            video_de,
    output logic [7:0]      video_r,
    output logic [7:0]      video_g,
    output logic [7:0]      video_b
);
    import cam_disp_pkg::*;

    cap_pixel_t  cap;        // capture -> store
    raster_pos_t pos;        // timing -> store read address
    video_ctl_t  raw_ctl;    // straight from the counters
    video_ctl_t  rd_ctl;     // aligned with rd_pix
    pixel_word_u rd_pix;
    video_ctl_t  out_ctl;
    rgb888_t     out_rgb;

    dvp_capture #(
        .IMAGE_WIDTH  (IMAGE_WIDTH),
        .IMAGE_HEIGHT (IMAGE_HEIGHT)
    ) dvp_capture_i (
        .pclk         (pclk),
        .rst          (rst),
        .camera_vsync (camera_vsync),
        .camera_href  (camera_href),
        .camera_data  (camera_data),
        .cap          (cap)
    );

    frame_store #(
        .IMAGE_WIDTH  (IMAGE_WIDTH),
        .IMAGE_HEIGHT (IMAGE_HEIGHT)
    ) frame_store_i (
        .pclk    (pclk),
        .rst     (rst),
        .cap     (cap),
        .pos     (pos),
        .ctl_in  (raw_ctl),
        .rd_pix  (rd_pix),
        .ctl_out (rd_ctl)
    );

    video_timing #(
        .IMAGE_WIDTH  (IMAGE_WIDTH),
        .IMAGE_HEIGHT (IMAGE_HEIGHT),
        .H_FRONT      (H_FRONT),
        .H_SYNC       (H_SYNC),
        .H_BACK       (H_BACK),
        .V_FRONT      (V_FRONT),
        .V_SYNC       (V_SYNC),
        .V_BACK       (V_BACK)
    ) video_timing_i (
        .pclk (pclk),
        .rst  (rst),
        .pos  (pos),
        .ctl  (raw_ctl)
    );

    pixel_expand pixel_expand_i (
        .pclk   (pclk),
        .rst    (rst),
        .rd_pix (rd_pix),
        .ctl_in (rd_ctl),
        .ctl    (out_ctl),
        .rgb    (out_rgb)
    );

    // pins for the tmds encoder
    assign video_hs = out_ctl.hs;
    assign video_vs = out_ctl.vs;
    assign video_de = out_ctl.de;
    assign video_r  = out_rgb.red;
    assign video_g  = out_rgb.green;
    assign video_b  = out_rgb.blue;

endmodule

`default_nettype wire

//--- test/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD = 8            // ns, camera and display share it
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    // free running, first rising edge after half a period
    always begin
        #(PERIOD / 2);
        clk = ~clk;
    end

endmodule

`default_nettype wire

//--- test/tb_cam_disp.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cam_disp;

    localparam int IMAGE_WIDTH  = 16;
    localparam int IMAGE_HEIGHT = 8;
    localparam int H_FRONT      = 2;
    localparam int H_SYNC       = 3;
    localparam int H_BACK       = 3;
    localparam int V_FRONT      = 1;
    localparam int V_SYNC       = 2;
    localparam int V_BACK       = 1;

    localparam int FRAME_PIXELS = IMAGE_WIDTH * IMAGE_HEIGHT;
    localparam int H_TOTAL      = IMAGE_WIDTH + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL      = IMAGE_HEIGHT + V_FRONT + V_SYNC + V_BACK;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int WAIT_LIMIT   = 2 * FRAME_CYCLES + 16;   // a bit over two frames
    localparam int LINE_GAP     = 4;                        // href low between lines

    logic       clk;
    logic       rst;
    logic       camera_vsync;
    logic       camera_href;
    logic [7:0] camera_data;
    logic       video_hs;
    logic       video_vs;
    logic       video_de;
    logic [7:0] video_r;
    logic [7:0] video_g;
    logic [7:0] video_b;

    logic [31:0] lcg_state;
    logic [15:0] src_pix   [0:FRAME_PIXELS-1];   // pattern the camera sends
    logic [15:0] exp_frame [0:FRAME_PIXELS-1];   // what the memory should hold
    int          model_wp;                       // model write pointer
    logic        blank_watch;

    tb_clock #(.PERIOD(8)) tb_clock_i (.clk(clk));

    cam_disp_top #(
        .IMAGE_WIDTH  (IMAGE_WIDTH),
        .IMAGE_HEIGHT (IMAGE_HEIGHT),
        .H_FRONT      (H_FRONT),
        .H_SYNC       (H_SYNC),
        .H_BACK       (H_BACK),
        .V_FRONT      (V_FRONT),
        .V_SYNC       (V_SYNC),
        .V_BACK       (V_BACK)
    ) cam_disp_top_i (
        .pclk         (clk),
        .rst          (rst),
        .camera_vsync (camera_vsync),
        .camera_href  (camera_href),
        .camera_data  (camera_data),
        .video_hs     (video_hs),
        .video_vs     (video_vs),
        .video_de     (video_de),
        .video_r      (video_r),
        .video_g      (video_g),
        .video_b      (video_b)
    );

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string test_name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Error: %s expected 0x%0h actual 0x%0h", test_name, expected, actual);
            stop_with_failure("mismatch");
        end
    endtask

    // 32-bit lcg, upper middle bits are the better ones
    function automatic logic [15:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[30:15];
    endfunction

    // rgb565 -> rgb888, zero low bits
    function automatic logic [23:0] expand565(input logic [15:0] w);
        return {w[15:11], 3'b000, w[10:5], 2'b00, w[4:0], 3'b000};
    endfunction

    task automatic fill_source();
        int i;
        for (i = 0; i < FRAME_PIXELS; i++)
            src_pix[i] = lcg_next();
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic wait_vs_rise(input string test_name);
        int   cycles;
        logic vs_prev;
        logic seen;
        cycles  = 0;
        seen    = 1'b0;
        vs_prev = video_vs;
        while (!seen) begin
            @(negedge clk);
            cycles++;
            if (video_vs && !vs_prev)
                seen = 1'b1;
            vs_prev = video_vs;
            if (!seen && cycles > WAIT_LIMIT)
                stop_with_failure({"timeout: no vs rising edge seen in ", test_name});
        end
    endtask

    // vsync pulse, the falling edge arms sof
    task automatic send_vsync();
        @(negedge clk);
        camera_vsync = 1'b1;
        idle_cycles(3);
        camera_vsync = 1'b0;
        model_wp = 0;
        idle_cycles(2);
    endtask

    // one href run, bytes pair from its own start
    task automatic send_run(input logic [7:0] run_bytes[$]);
        int i;
        for (i = 0; i < run_bytes.size(); i++) begin
            @(negedge clk);
            camera_href = 1'b1;
            camera_data = run_bytes[i];
        end
        @(negedge clk);
        camera_href = 1'b0;
        camera_data = 8'h00;
        for (i = 0; i + 1 < run_bytes.size(); i += 2) begin
            if (model_wp < FRAME_PIXELS)        // extra pixels dropped
                exp_frame[model_wp] = {run_bytes[i], run_bytes[i + 1]};
            model_wp++;
        end
    endtask

    // split_line < 0 means no href break inside a line
    task automatic send_frame(input int n_lines, input int split_line, input int split_at);
        logic [7:0] run_bytes[$];
        int         l;
        int         x;
        send_vsync();
        for (l = 0; l < n_lines; l++) begin
            run_bytes = {};
            for (x = 0; x < IMAGE_WIDTH; x++) begin
                if (l == split_line && x == split_at) begin
                    run_bytes.push_back(8'ha5);   // dangling first byte, lost
                    send_run(run_bytes);
                    idle_cycles(3);
                    run_bytes = {};
                end
                run_bytes.push_back(src_pix[l * IMAGE_WIDTH + x][15:8]);
                run_bytes.push_back(src_pix[l * IMAGE_WIDTH + x][7:0]);
            end
            send_run(run_bytes);
            idle_cycles(LINE_GAP);
        end
    endtask

    // next whole displayed frame against the model, pixels found by de count
    task automatic check_display(input string test_name);
        int idx;
        int cycles;
        wait_vs_rise(test_name);
        idx    = 0;
        cycles = 0;
        while (idx < FRAME_PIXELS) begin
            @(negedge clk);
            cycles++;
            if (video_de) begin
                check_value(test_name, 32'(expand565(exp_frame[idx])),
                            32'({video_r, video_g, video_b}));
                idx++;
            end else if (cycles > WAIT_LIMIT) begin
                stop_with_failure({"timeout: displayed frame incomplete in ", test_name});
            end
        end
    endtask

    task automatic test_reset_state();
        rst = 1'b1;
        repeat (3) begin
            @(negedge clk);
            check_value("reset_state", 32'd0, 32'({video_hs, video_vs, video_de}));
        end
        rst = 1'b0;
        @(negedge clk);                               // first cycle out of reset
        check_value("reset_state", 32'd0, 32'({video_hs, video_vs, video_de}));
    endtask

    task automatic test_raster();
        int   cycles;
        int   de_total;
        int   de_run;
        int   de_lines;
        int   hs_pulses;
        int   hs_len;
        logic de_d;
        logic hs_d;
        logic vs_d;
        logic done;
        wait_vs_rise("raster");
        cycles    = 0;
        de_total  = 0;
        de_run    = 0;
        de_lines  = 0;
        hs_pulses = 0;
        hs_len    = 0;
        de_d      = video_de;
        hs_d      = video_hs;
        vs_d      = video_vs;
        done      = 1'b0;
        while (!done) begin
            @(negedge clk);
            cycles++;
            if (video_de) begin
                de_total++;
                de_run++;
            end
            if (de_d && !video_de) begin              // end of an active line
                check_value("raster de per line", IMAGE_WIDTH, de_run);
                de_lines++;
                de_run = 0;
            end
            if (video_hs) begin
                hs_len++;
                if (!hs_d)
                    hs_pulses++;
            end else if (hs_d) begin
                check_value("raster hs width", H_SYNC, hs_len);
                hs_len = 0;
            end
            if (video_vs && !vs_d)
                done = 1'b1;
            de_d = video_de;
            hs_d = video_hs;
            vs_d = video_vs;
            if (!done && cycles > WAIT_LIMIT)
                stop_with_failure("timeout: second vs rising edge missing in raster");
        end
        check_value("raster de per frame", FRAME_PIXELS, de_total);
        check_value("raster lines", IMAGE_HEIGHT, de_lines);
        check_value("raster hs per frame", V_TOTAL, hs_pulses);
    endtask

    task automatic test_frame_capture();
        fill_source();
        send_frame(IMAGE_HEIGHT, -1, 0);
        check_display("frame_capture");
    endtask

    task automatic test_blanking();
        int   cycles;
        int   blank;
        logic vs_d;
        logic done;
        wait_vs_rise("blanking");
        cycles = 0;
        blank  = 0;
        vs_d   = video_vs;
        done   = 1'b0;
        while (!done) begin
            @(negedge clk);
            cycles++;
            if (video_vs && !vs_d) begin
                done = 1'b1;
            end else if (!video_de) begin
                check_value("blanking", 32'd0, 32'({video_r, video_g, video_b}));
                blank++;
            end
            vs_d = video_vs;
            if (!done && cycles > WAIT_LIMIT)
                stop_with_failure("timeout: frame end missing in blanking");
        end
        // the closing vs edge itself is blank too
        check_value("blanking cycles", FRAME_CYCLES - FRAME_PIXELS, blank + 1);
    endtask

    task automatic test_frame_restart();
        fill_source();
        send_frame(3, -1, 0);                         // cut off after 3 lines
        fill_source();
        send_frame(IMAGE_HEIGHT, -1, 0);
        check_display("frame_restart");
    endtask

    task automatic test_byte_pairing();
        fill_source();
        send_frame(IMAGE_HEIGHT, 2, 5);               // href break in line 2
        check_display("byte_pairing");
    endtask

    // de low means black, all the time after reset
    always @(negedge clk) begin
        if (blank_watch && !video_de)
            check_value("blanking watch", 32'd0, 32'({video_r, video_g, video_b}));
    end

    initial begin
        lcg_state    = 32'd67515;
        model_wp     = 0;
        blank_watch  = 1'b0;
        rst          = 1'b1;
        camera_vsync = 1'b0;
        camera_href  = 1'b0;
        camera_data  = 8'h00;

        test_reset_state();
        blank_watch = 1'b1;
        test_raster();
        test_frame_capture();
        test_blanking();
        test_frame_restart();
        test_byte_pairing();

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
verilog/cam_disp_pkg.sv
verilog/dvp_capture.sv
verilog/frame_store.sv
verilog/video_timing.sv
verilog/pixel_expand.sv
verilog/cam_disp_top.sv
test/tb_clock.sv
test/tb_cam_disp.sv

//--- run.sh
#!/bin/sh
# build with Verilator and run; $fatal gives a failing exit status
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f project.f --top-module tb_cam_disp -o sim_cam_disp
./obj_dir/sim_cam_disp
